/* common/alu_pkg.sv */
package alu_pkg;

        localparam int unsigned WORD_W     = 32;
        localparam int unsigned REG_ADDR_W = 5;
        localparam int unsigned SHAMT_W    = 5;

        typedef logic [WORD_W-1:0]     word_t;
        typedef logic [WORD_W-1:0]     instr_t;
        typedef logic [REG_ADDR_W-1:0] reg_addr_t;
        typedef logic [SHAMT_W-1:0]    shamt_t;
        typedef logic [5:0]            opcode_t;
        typedef logic [5:0]            funct_t;

        typedef enum logic [3:0] {
                OP_SLL, OP_SRL, OP_SRA, OP_ADD, OP_SUB,
                OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT,
                OP_BEQ, OP_BNE, OP_LUI, OP_MUL, OP_DIV
        } alu_op_t;

        localparam opcode_t OPC_RTYPE = 6'h00;
        localparam opcode_t OPC_BEQ   = 6'h04;
        localparam opcode_t OPC_BNE   = 6'h05;
        localparam opcode_t OPC_ADDI  = 6'h08;
        localparam opcode_t OPC_ANDI  = 6'h0c;
        localparam opcode_t OPC_ORI   = 6'h0d;
        localparam opcode_t OPC_XORI  = 6'h0e;
        localparam opcode_t OPC_LUI   = 6'h0f;

        localparam funct_t FN_SLL = 6'h00;
        localparam funct_t FN_SRL = 6'h02;
        localparam funct_t FN_SRA = 6'h03;
        localparam funct_t FN_MUL = 6'h18;
        localparam funct_t FN_DIV = 6'h1a;
        localparam funct_t FN_ADD = 6'h20;
        localparam funct_t FN_SUB = 6'h22;
        localparam funct_t FN_AND = 6'h24;
        localparam funct_t FN_OR  = 6'h25;
        localparam funct_t FN_XOR = 6'h26;
        localparam funct_t FN_NOR = 6'h27;
        localparam funct_t FN_SLT = 6'h2a;

        typedef struct packed {
                logic      valid;
                alu_op_t   op;
                reg_addr_t rs_addr;
                reg_addr_t rt_addr;
                reg_addr_t dest;
                logic      writes;    // Never set for register 0
                logic      use_imm;
                word_t     imm;       // Already extended to full width
                shamt_t    shamt;
                word_t     rs_val;
                word_t     rt_val;
        } decoded_t;

        typedef struct packed {
                logic      valid;
                logic      writes;
                reg_addr_t dest;
                word_t     value;
                logic      overflow;
                logic      is_branch;
                logic      taken;
        } result_t;

endpackage

/* source/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
        input  logic               clk,
        input  logic               arst_n,
        input  logic               instr_valid,
        input  alu_pkg::instr_t    instr,
        output alu_pkg::reg_addr_t rd_addr_a,
        output alu_pkg::reg_addr_t rd_addr_b,
        input  alu_pkg::word_t     rd_data_a,
        input  alu_pkg::word_t     rd_data_b,
        output alu_pkg::decoded_t  dec,
        output logic               illegal
);

        import alu_pkg::*;

        opcode_t  opcode;
        funct_t   funct;
        word_t    imm_sext;
        word_t    imm_zext;
        logic     legal;
        decoded_t dec_d;

        assign opcode    = instr[31:26];
        assign funct     = instr[5:0];
        assign imm_sext  = {{16{instr[15]}}, instr[15:0]};
        assign imm_zext  = {16'h0000, instr[15:0]};
        assign rd_addr_a = instr[25:21];
        assign rd_addr_b = instr[20:16];

        always_comb begin
                dec_d         = '0;
                legal         = 1'b1;
                dec_d.rs_addr = instr[25:21];
                dec_d.rt_addr = instr[20:16];
                dec_d.shamt   = instr[10:6];
                dec_d.rs_val  = rd_data_a;
                dec_d.rt_val  = rd_data_b;
                dec_d.imm     = imm_sext;
                case (opcode)
                        OPC_RTYPE: begin
                                dec_d.dest   = instr[15:11];
                                dec_d.writes = 1'b1;
                                case (funct)
                                        FN_SLL:  dec_d.op = OP_SLL;
                                        FN_SRL:  dec_d.op = OP_SRL;
                                        FN_SRA:  dec_d.op = OP_SRA;
                                        FN_ADD:  dec_d.op = OP_ADD;
                                        FN_SUB:  dec_d.op = OP_SUB;
                                        FN_AND:  dec_d.op = OP_AND;
                                        FN_OR:   dec_d.op = OP_OR;
                                        FN_XOR:  dec_d.op = OP_XOR;
                                        FN_NOR:  dec_d.op = OP_NOR;
                                        FN_SLT:  dec_d.op = OP_SLT;
                                        FN_MUL:  dec_d.op = OP_MUL;
                                        FN_DIV:  dec_d.op = OP_DIV;
                                        default: legal    = 1'b0;
                                endcase
                        end
                        OPC_BEQ: dec_d.op = OP_BEQ; // Compares rs with rt so no immediate operand
                        OPC_BNE: dec_d.op = OP_BNE;
                        default: begin
                                dec_d.dest    = instr[20:16];
                                dec_d.writes  = 1'b1;
                                dec_d.use_imm = 1'b1;
                                dec_d.imm     = imm_zext;
                                case (opcode)
                                        OPC_ADDI: begin
                                                dec_d.op  = OP_ADD;
                                                dec_d.imm = imm_sext;
                                        end
                                        OPC_ANDI: dec_d.op = OP_AND;
                                        OPC_ORI:  dec_d.op = OP_OR;
                                        OPC_XORI: dec_d.op = OP_XOR;
                                        OPC_LUI:  dec_d.op = OP_LUI;
                                        default:  legal    = 1'b0;
                                endcase
                        end
                endcase
                if (dec_d.dest == '0) begin
                        dec_d.writes = 1'b0; // Register 0 is never written
                end
                dec_d.valid = instr_valid && legal;
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        dec     <= '0;
                        illegal <= 1'b0;
                end else begin
                        dec     <= dec_d;
                        illegal <= instr_valid && !legal;
                end
        end

        a_valid_xor_illegal: assert property (@(posedge clk) disable iff (!arst_n)
                instr_valid |=> (dec.valid != illegal))
                else $error("Decoder gave both or neither of a decoded op and illegal");

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
        input  logic               clk,
        input  logic               arst_n,
        input  alu_pkg::reg_addr_t rd_addr_a,
        input  alu_pkg::reg_addr_t rd_addr_b,
        output alu_pkg::word_t     rd_data_a,
        output alu_pkg::word_t     rd_data_b,
        input  logic               wr_en,
        input  alu_pkg::reg_addr_t wr_addr,
        input  alu_pkg::word_t     wr_data
);

        import alu_pkg::*;

        word_t regs [1:31];

        // Same-cycle write data wins over the stored value
        function automatic word_t read_port(reg_addr_t addr);
                if (addr == '0) begin
                        return '0;
                end
                if (wr_en && (wr_addr == addr)) begin
                        return wr_data;
                end
                return regs[addr];
        endfunction

        always_comb begin
                rd_data_a = read_port(rd_addr_a);
                rd_data_b = read_port(rd_addr_b);
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        for (int i = 1; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wr_en && (wr_addr != '0)) begin
                        regs[wr_addr] <= wr_data;
                end
        end

        // Decode clears writes to register 0 so writeback must never carry one
        a_no_write_r0: assert property (@(posedge clk) disable iff (!arst_n)
                wr_en |-> (wr_addr != '0))
                else $error("Writeback targeted register 0");

endmodule

/* execute/alu.sv */
`timescale 1ns/1ps

module alu (
        input  alu_pkg::alu_op_t op,
        input  alu_pkg::word_t   a,
        input  alu_pkg::word_t   b,
        input  alu_pkg::shamt_t  shamt,
        output alu_pkg::word_t   result,
        output logic             overflow,
        output logic             cond
);

        import alu_pkg::*;

        word_t       sum;
        word_t       diff;
        logic [63:0] prod;

        assign sum  = a + b;
        assign diff = a - b;
        assign prod = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // Low 64 bits are the signed product

        always_comb begin
                result   = '0;
                overflow = 1'b0;
                cond     = 1'b0;
                assert final (!$isunknown(op))
                        else $error("ALU received an unknown operation");
                case (op)
                        OP_SLL: begin
                                result = b << shamt;
                        end
                        OP_SRL: begin
                                result = b >> shamt;
                        end
                        OP_SRA: begin
                                result = word_t'($signed(b) >>> shamt);
                        end
                        OP_ADD: begin
                                result   = sum;
                                overflow = (a[31] == b[31]) && (sum[31] != a[31]);
                        end
                        OP_SUB: begin
                                result   = diff;
                                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
                        end
                        OP_AND: begin
                                result = a & b;
                        end
                        OP_OR: begin
                                result = a | b;
                        end
                        OP_XOR: begin
                                result = a ^ b;
                        end
                        OP_NOR: begin
                                result = ~(a | b);
                        end
                        OP_SLT: begin
                                result = {31'b0, $signed(a) < $signed(b)};
                        end
                        OP_BEQ: begin
                                cond = (diff == '0);
                        end
                        OP_BNE: begin
                                cond = (diff != '0);
                        end
                        OP_LUI: begin
                                result = {b[15:0], 16'h0000};
                        end
                        OP_MUL: begin
                                result   = prod[31:0];
                                overflow = (prod[63:32] != {32{prod[31]}});
                        end
                        OP_DIV: begin
                                if (b == '0) begin
                                        overflow = 1'b1; // Quotient stays zero
                                end else begin
                                        result = word_t'($signed(a) / $signed(b));
                                end
                        end
                        default: begin
                                result = '0;
                        end
                endcase
        end

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
        input  logic              clk,
        input  logic              arst_n,
        input  alu_pkg::decoded_t dec,
        output alu_pkg::result_t  res
);

        import alu_pkg::*;

        logic    fwd_hit_rs;
        logic    fwd_hit_rt;
        word_t   fwd_rs;
        word_t   fwd_rt;
        word_t   op_b;
        word_t   alu_result;
        logic    alu_overflow;
        logic    alu_cond;
        result_t res_d;

        // Result register holds the instruction one slot ahead
        assign fwd_hit_rs = res.valid && res.writes && (dec.rs_addr != '0)
                            && (res.dest == dec.rs_addr);
        assign fwd_hit_rt = res.valid && res.writes && (dec.rt_addr != '0)
                            && (res.dest == dec.rt_addr);

        assign fwd_rs = fwd_hit_rs ? res.value : dec.rs_val;
        assign fwd_rt = fwd_hit_rt ? res.value : dec.rt_val;
        assign op_b   = dec.use_imm ? dec.imm : fwd_rt;

        alu u_alu (
                .op       (dec.op),
                .a        (fwd_rs),
                .b        (op_b),
                .shamt    (dec.shamt),
                .result   (alu_result),
                .overflow (alu_overflow),
                .cond     (alu_cond)
        );

        always_comb begin
                res_d           = '0;
                res_d.valid     = dec.valid;
                res_d.writes    = dec.writes;
                res_d.dest      = dec.dest;
                res_d.value     = alu_result;
                res_d.overflow  = alu_overflow;
                res_d.is_branch = (dec.op == OP_BEQ) || (dec.op == OP_BNE);
                res_d.taken     = alu_cond;
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        res <= '0;
                end else begin
                        res <= res_d;
                end
        end

        a_write_or_branch: assert property (@(posedge clk) disable iff (!arst_n)
                res.valid |-> !(res.writes && res.is_branch))
                else $error("Result marked as both a register write and a branch");

endmodule

/* source/alu_pipeline.sv */
`timescale 1ns/1ps

module alu_pipeline (
        input  logic               clk,
        input  logic               arst_n,
        input  logic               instr_valid,
        input  alu_pkg::instr_t    instr,
        output logic               illegal,
        output logic               wb_valid,
        output alu_pkg::reg_addr_t wb_dest,
        output alu_pkg::word_t     wb_value,
        output logic               wb_overflow,
        output logic               branch_valid,
        output logic               branch_taken
);

        import alu_pkg::*;

        reg_addr_t rd_addr_a;
        reg_addr_t rd_addr_b;
        word_t     rd_data_a;
        word_t     rd_data_b;
        decoded_t  dec;
        result_t   res;

        instr_decoder u_decoder (
                .clk         (clk),
                .arst_n      (arst_n),
                .instr_valid (instr_valid),
                .instr       (instr),
                .rd_addr_a   (rd_addr_a),
                .rd_addr_b   (rd_addr_b),
                .rd_data_a   (rd_data_a),
                .rd_data_b   (rd_data_b),
                .dec         (dec),
                .illegal     (illegal)
        );

        // Writeback port is the execute result register itself
        reg_file u_reg_file (
                .clk       (clk),
                .arst_n    (arst_n),
                .rd_addr_a (rd_addr_a),
                .rd_addr_b (rd_addr_b),
                .rd_data_a (rd_data_a),
                .rd_data_b (rd_data_b),
                .wr_en     (wb_valid),
                .wr_addr   (res.dest),
                .wr_data   (res.value)
        );

        execute_stage u_execute (
                .clk    (clk),
                .arst_n (arst_n),
                .dec    (dec),
                .res    (res)
        );

        assign wb_valid     = res.valid && res.writes;
        assign wb_dest      = res.dest;
        assign wb_value     = res.value;
        assign wb_overflow  = wb_valid && res.overflow;
        assign branch_valid = res.valid && res.is_branch;
        assign branch_taken = branch_valid && res.taken;

endmodule

/* testbench/tb_alu_pipeline.sv */
`timescale 1ns/1ps

module tb_alu_pipeline;

        import alu_pkg::*;

        typedef struct packed {
                instr_t    instr;
                logic      gap;       // Leaves instr_valid low for one cycle after the entry
                logic      illegal;
                logic      writes;
                logic      is_branch;
                reg_addr_t dest;
                word_t     value;
                logic      overflow;
                logic      taken;
        } entry_t;

        localparam longint WORD_MAX = 64'sd2147483647;
        localparam longint WORD_MIN = -64'sd2147483648;

        logic      clk;
        logic      arst_n;
        logic      instr_valid;
        instr_t    instr;
        logic      illegal;
        logic      wb_valid;
        reg_addr_t wb_dest;
        word_t     wb_value;
        logic      wb_overflow;
        logic      branch_valid;
        logic      branch_taken;

        word_t  model_regs [32];
        entry_t table_q [$];
        entry_t pending_q [$]; // One entry per cycle, idle cycles included
        integer seed;
        int     errors;
        int     checks;
        int     cycles;
        int     cycle_limit;
        logic   table_ready = 1'b0;

        alu_pipeline dut (
                .clk          (clk),
                .arst_n       (arst_n),
                .instr_valid  (instr_valid),
                .instr        (instr),
                .illegal      (illegal),
                .wb_valid     (wb_valid),
                .wb_dest      (wb_dest),
                .wb_value     (wb_value),
                .wb_overflow  (wb_overflow),
                .branch_valid (branch_valid),
                .branch_taken (branch_taken)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        function automatic instr_t rtype(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                         shamt_t sh);
                return {OPC_RTYPE, rs, rt, rd, sh, fn};
        endfunction

        function automatic instr_t itype(opcode_t opc, reg_addr_t rs, reg_addr_t rt,
                                         logic [15:0] imm);
                return {opc, rs, rt, imm};
        endfunction

        // Sequential reference model where exact 64-bit arithmetic decides overflow
        function automatic entry_t model_entry(instr_t w, logic gap);
                entry_t    e;
                reg_addr_t dest;
                logic      known;
                logic      branch;
                logic      taken;
                logic      ovf;
                word_t     a;
                word_t     b;
                word_t     value;
                longint    sa;
                longint    sb;
                longint    si;
                longint    r64;
                e      = '0;
                known  = 1'b1;
                branch = 1'b0;
                taken  = 1'b0;
                ovf    = 1'b0;
                value  = '0;
                a      = model_regs[w[25:21]];
                b      = model_regs[w[20:16]];
                sa     = $signed(a);
                sb     = $signed(b);
                si     = $signed(w[15:0]);
                dest   = w[20:16];
                case (w[31:26])
                        OPC_RTYPE: begin
                                dest = w[15:11];
                                case (w[5:0])
                                        FN_SLL: value = b << w[10:6];
                                        FN_SRL: value = b >> w[10:6];
                                        FN_SRA: value = word_t'(sb >>> w[10:6]);
                                        FN_ADD: r64 = sa + sb;
                                        FN_SUB: r64 = sa - sb;
                                        FN_MUL: r64 = sa * sb;
                                        FN_AND: value = a & b;
                                        FN_OR:  value = a | b;
                                        FN_XOR: value = a ^ b;
                                        FN_NOR: value = ~(a | b);
                                        FN_SLT: value = (sa < sb) ? 32'd1 : 32'd0;
                                        FN_DIV: begin
                                                ovf   = (b == '0);
                                                value = ovf ? '0 : word_t'(sa / sb);
                                        end
                                        default: known = 1'b0;
                                endcase
                                if (w[5:0] inside {FN_ADD, FN_SUB, FN_MUL}) begin
                                        value = r64[31:0];
                                        ovf   = (r64 > WORD_MAX) || (r64 < WORD_MIN);
                                end
                        end
                        OPC_ADDI: begin
                                r64   = sa + si;
                                value = r64[31:0];
                                ovf   = (r64 > WORD_MAX) || (r64 < WORD_MIN);
                        end
                        OPC_ANDI: value = a & {16'h0000, w[15:0]};
                        OPC_ORI:  value = a | {16'h0000, w[15:0]};
                        OPC_XORI: value = a ^ {16'h0000, w[15:0]};
                        OPC_LUI:  value = {w[15:0], 16'h0000};
                        OPC_BEQ: begin
                                branch = 1'b1;
                                taken  = (a == b);
                        end
                        OPC_BNE: begin
                                branch = 1'b1;
                                taken  = (a != b);
                        end
                        default: known = 1'b0;
                endcase
                e.instr = w;
                e.gap   = gap;
                if (!known) begin
                        e.illegal = 1'b1;
                end else if (branch) begin
                        e.is_branch = 1'b1;
                        e.taken     = taken;
                end else if (dest != '0) begin
                        e.writes        = 1'b1;
                        e.dest          = dest;
                        e.value         = value;
                        e.overflow      = ovf;
                        model_regs[dest] = value;
                end
                return e;
        endfunction

        function automatic funct_t pick_funct(logic [3:0] k);
                case (k)
                        4'd0:    return FN_SLL;
                        4'd1:    return FN_SRL;
                        4'd2:    return FN_SRA;
                        4'd3:    return FN_SUB;
                        4'd4:    return FN_AND;
                        4'd5:    return FN_OR;
                        4'd6:    return FN_XOR;
                        4'd7:    return FN_NOR;
                        4'd8:    return FN_SLT;
                        4'd9:    return FN_MUL;
                        default: return FN_ADD;
                endcase
        endfunction

        function automatic opcode_t pick_opcode(logic [2:0] k);
                case (k)
                        3'd1:    return OPC_ANDI;
                        3'd2:    return OPC_ORI;
                        3'd3:    return OPC_XORI;
                        3'd4:    return OPC_LUI;
                        3'd5:    return OPC_BEQ;
                        3'd6:    return OPC_BNE;
                        default: return OPC_ADDI;
                endcase
        endfunction

        task automatic add_entry(instr_t w, logic gap);
                table_q.push_back(model_entry(w, gap));
        endtask

        task automatic build_table();
                logic [31:0] rnd;
                for (int r = 1; r < 32; r++) begin
                        add_entry(rtype(FN_ADD, reg_addr_t'(r), 5'd0, reg_addr_t'(r), 5'd0), 1'b0);
                end
                add_entry(itype(OPC_ADDI, 5'd0, 5'd1, 16'h7fff), 1'b0);
                add_entry(itype(OPC_LUI, 5'd0, 5'd2, 16'h7fff), 1'b0);
                add_entry(itype(OPC_ORI, 5'd2, 5'd2, 16'hffff), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd0, 5'd3, 16'h0001), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd0, 5'd5, 16'hffff), 1'b0);
                add_entry(itype(OPC_LUI, 5'd0, 5'd6, 16'h8000), 1'b1);
                add_entry(rtype(FN_ADD, 5'd2, 5'd3, 5'd4, 5'd0), 1'b0); // Signed overflow
                add_entry(rtype(FN_SUB, 5'd6, 5'd3, 5'd7, 5'd0), 1'b0);
                add_entry(rtype(FN_SUB, 5'd3, 5'd5, 5'd8, 5'd0), 1'b0);
                add_entry(rtype(FN_ADD, 5'd5, 5'd5, 5'd4, 5'd0), 1'b0);
                add_entry(rtype(FN_AND, 5'd2, 5'd6, 5'd10, 5'd0), 1'b0);
                add_entry(rtype(FN_OR, 5'd1, 5'd6, 5'd11, 5'd0), 1'b0);
                add_entry(rtype(FN_XOR, 5'd5, 5'd1, 5'd12, 5'd0), 1'b0);
                add_entry(rtype(FN_NOR, 5'd1, 5'd3, 5'd13, 5'd0), 1'b0);
                add_entry(rtype(FN_SLT, 5'd6, 5'd3, 5'd14, 5'd0), 1'b0);
                add_entry(rtype(FN_SLT, 5'd3, 5'd6, 5'd15, 5'd0), 1'b0);
                add_entry(rtype(FN_SLL, 5'd0, 5'd5, 5'd9, 5'd4), 1'b0);
                add_entry(rtype(FN_SRL, 5'd0, 5'd6, 5'd16, 5'd31), 1'b0);
                add_entry(rtype(FN_SRA, 5'd0, 5'd6, 5'd17, 5'd4), 1'b0);
                add_entry(rtype(FN_MUL, 5'd2, 5'd2, 5'd18, 5'd0), 1'b0); // High word not sign
                add_entry(rtype(FN_MUL, 5'd5, 5'd5, 5'd19, 5'd0), 1'b0);
                add_entry(rtype(FN_MUL, 5'd6, 5'd5, 5'd20, 5'd0), 1'b0);
                add_entry(rtype(FN_MUL, 5'd1, 5'd1, 5'd21, 5'd0), 1'b0);
                add_entry(rtype(FN_DIV, 5'd6, 5'd8, 5'd22, 5'd0), 1'b0);
                add_entry(rtype(FN_DIV, 5'd2, 5'd0, 5'd23, 5'd0), 1'b0); // Divide by zero
                add_entry(rtype(FN_DIV, 5'd5, 5'd8, 5'd24, 5'd0), 1'b0);
                add_entry(itype(OPC_ANDI, 5'd5, 5'd25, 16'h8001), 1'b0);
                add_entry(itype(OPC_XORI, 5'd25, 5'd25, 16'hffff), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd6, 5'd26, 16'hffff), 1'b0);
                // Dependency chains at distances 1, 2 and 3, then stretched by gaps
                add_entry(itype(OPC_ADDI, 5'd0, 5'd20, 16'h0005), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd20, 5'd20, 16'h0003), 1'b0);
                add_entry(rtype(FN_ADD, 5'd20, 5'd20, 5'd21, 5'd0), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd0, 5'd22, 16'h0007), 1'b0);
                add_entry(rtype(FN_ADD, 5'd20, 5'd22, 5'd23, 5'd0), 1'b0);
                add_entry(rtype(FN_SUB, 5'd21, 5'd3, 5'd24, 5'd0), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd0, 5'd27, 16'h000b), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd0, 5'd28, 16'h0002), 1'b0);
                add_entry(rtype(FN_ADD, 5'd27, 5'd28, 5'd29, 5'd0), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd27, 5'd27, 16'h0001), 1'b1);
                add_entry(rtype(FN_ADD, 5'd27, 5'd27, 5'd28, 5'd0), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd0, 5'd29, 16'h0003), 1'b1);
                add_entry(itype(OPC_ADDI, 5'd0, 5'd30, 16'h0004), 1'b1);
                add_entry(rtype(FN_ADD, 5'd29, 5'd30, 5'd31, 5'd0), 1'b0);
                add_entry(itype(OPC_BEQ, 5'd3, 5'd3, 16'h0010), 1'b0);
                add_entry(itype(OPC_BEQ, 5'd3, 5'd5, 16'h0010), 1'b0);
                add_entry(itype(OPC_BNE, 5'd3, 5'd5, 16'hfff0), 1'b0);
                add_entry(itype(OPC_BNE, 5'd0, 5'd0, 16'hfff0), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd0, 5'd29, 16'h0004), 1'b0);
                add_entry(itype(OPC_BEQ, 5'd29, 5'd30, 16'h0008), 1'b0);
                add_entry(itype(OPC_BNE, 5'd29, 5'd28, 16'h0008), 1'b0);
                add_entry(itype(OPC_ADDI, 5'd3, 5'd0, 16'h0005), 1'b0);
                add_entry(rtype(FN_ADD, 5'd1, 5'd2, 5'd0, 5'd0), 1'b0);
                // Illegal encodings aim at r9, which is read back afterwards
                add_entry(itype(6'h3f, 5'd0, 5'd9, 16'h1234), 1'b0);
                add_entry(rtype(6'h01, 5'd1, 5'd2, 5'd9, 5'd0), 1'b0);
                add_entry(itype(6'h23, 5'd3, 5'd9, 16'h0004), 1'b1);
                add_entry(rtype(FN_ADD, 5'd9, 5'd0, 5'd30, 5'd0), 1'b0);
                for (int i = 0; i < 48; i++) begin
                        rnd = $random(seed);
                        if (rnd[0]) begin
                                add_entry(rtype(pick_funct(rnd[4:1]), rnd[9:5], rnd[14:10],
                                                rnd[19:15], rnd[24:20]), rnd[27:25] == 3'b000);
                        end else begin
                                add_entry(itype(pick_opcode(rnd[3:1]), rnd[9:5], rnd[14:10],
                                                rnd[31:16]), rnd[27:25] == 3'b000);
                        end
                end
        endtask

        task automatic check_value(string name, word_t got, word_t want);
                checks++;
                assert (got === want) else begin
                        errors++;
                        $display("[ERROR] %s = %h, expected %h at %0t", name, got, want, $time);
                end
        endtask

        task automatic check_result(entry_t e);
                check_value("wb_valid", wb_valid, e.writes);
                check_value("wb_overflow", wb_overflow, e.writes && e.overflow);
                check_value("branch_valid", branch_valid, e.is_branch);
                check_value("branch_taken", branch_taken, e.is_branch && e.taken);
                if (e.writes) begin
                        check_value("wb_dest", wb_dest, e.dest);
                        check_value("wb_value", wb_value, e.value);
                end
        endtask

        // Illegal shows one cycle after issue, writeback and branch results two cycles after
        task automatic run_cycle(logic drive, entry_t e);
                @(negedge clk);
                if (pending_q.size() > 0) begin
                        check_value("illegal", illegal, pending_q[$].illegal);
                end
                if (pending_q.size() == 2) begin
                        check_result(pending_q.pop_front());
                end
                instr_valid = drive;
                instr       = drive ? e.instr : '0;
                pending_q.push_back(drive ? e : entry_t'('0));
        endtask

        initial begin
                cycles = 0;
                wait (table_ready);
                while (cycles < cycle_limit) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("Something failed");
                $finish;
        end

        initial begin
                arst_n      = 1'b0;
                instr_valid = 1'b0;
                instr       = '0;
                errors      = 0;
                checks      = 0;
                seed        = 32'h4fc4;
                foreach (model_regs[r]) begin
                        model_regs[r] = '0;
                end
                build_table();
                cycle_limit = 2 * table_q.size() + 50;
                table_ready = 1'b1;
                repeat (10) @(posedge clk);
                @(negedge clk);
                arst_n = 1'b1;
                repeat (3) run_cycle(1'b0, '0);
                foreach (table_q[i]) begin
                        run_cycle(1'b1, table_q[i]);
                        if (table_q[i].gap) begin
                                run_cycle(1'b0, '0);
                        end
                end
                repeat (3) run_cycle(1'b0, '0);
                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

/* alu_pipeline.f */
common/alu_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
execute/alu.sv
execute/execute_stage.sv
source/alu_pipeline.sv
testbench/tb_alu_pipeline.sv

/* Bender.yml */
package:
  name: alu_pipeline

dependencies: {}

sources:
  - common/alu_pkg.sv
  - source/instr_decoder.sv
  - source/reg_file.sv
  - execute/alu.sv
  - execute/execute_stage.sv
  - source/alu_pipeline.sv
  - target: test
    files:
      - testbench/tb_alu_pipeline.sv
